// File: verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

  // ==========================================================================
  // window geometry and data types
  // ==========================================================================

  localparam int WIN = 7;  // window side length.

  typedef logic [7:0]  pixel_t;   // greyscale pixel.
  typedef logic [13:0] result_t;  // fits 49 x 255.

  typedef enum logic [1:0] {
    OP_SUM = 2'd0,
    OP_MAX = 2'd1,
    OP_MIN = 2'd2
  } op_t;

  // ==========================================================================
  // link controller states
  // ==========================================================================

  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,  // waiting for a pixel.
    ST_ACK      = 3'd1,  // pixel acknowledged.
    ST_WAIT_WIN = 3'd2,  // result on its way.
    ST_RES_REQ  = 3'd3,
    ST_RES_DROP = 3'd4
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/window_if.sv
`default_nettype none

interface window_if import conv_pkg::*; ();

  pixel_t [WIN*WIN-1:0] win;         // index 0 is top row, oldest column.
  logic                 win_valid;   // one cycle per full window.
  logic                 frame_last;  // last window position of the image.

  modport dp (
    output win,
    output win_valid,
    output frame_last
  );

  modport red (
    input win,
    input win_valid,
    input frame_last
  );

endinterface

`default_nettype wire

// File: verilog/line_buffer.sv
`default_nettype none

module line_buffer import conv_pkg::*; #(
  parameter int COLS = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             shift_en_i,
  input  pixel_t           pix_i,
  output pixel_t [WIN-1:0] taps_o
);

  localparam int NLINES = WIN - 1;

  // line l holds the last COLS pixels that entered it.
  pixel_t line_q [NLINES][COLS];

  // ==========================================================================
  // chained row lines
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int l = 0; l < NLINES; l++) begin
        for (int c = 0; c < COLS; c++) begin
          line_q[l][c] <= '0;
        end
      end
    end else if (shift_en_i) begin
      for (int l = 0; l < NLINES; l++) begin
        line_q[l][0] <= taps_o[l];  // fed by the line above in the chain.
        for (int c = 1; c < COLS; c++) begin
          line_q[l][c] <= line_q[l][c-1];
        end
      end
    end
  end

  // tap k is the pixel k rows above the incoming one.
  always_comb begin
    taps_o[0] = pix_i;
    for (int k = 1; k < WIN; k++) begin
      taps_o[k] = line_q[k-1][COLS-1];
    end
  end

endmodule

`default_nettype wire

// File: verilog/window_7x7_datapath.sv
`default_nettype none

module window_7x7_datapath import conv_pkg::*; #(
  parameter int COLS = 16,
  parameter int ROWS = 12
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             shift_en_i,
  input  pixel_t [WIN-1:0] taps_i,
  output logic             win_full_o,
  window_if.dp             wbus
);

  localparam int CW = $clog2(COLS);
  localparam int RW = $clog2(ROWS);

  logic [CW-1:0]        col_q;
  logic [RW-1:0]        row_q;
  logic                 col_last;
  logic                 row_last;
  logic                 in_image;
  pixel_t [WIN*WIN-1:0] win_q;
  logic                 win_full_q;
  logic                 win_valid_q;
  logic                 frame_last_q;

  // position of the pixel being taken.
  assign col_last = (col_q == CW'(COLS - 1));
  assign row_last = (row_q == RW'(ROWS - 1));
  assign in_image = (col_q >= CW'(WIN - 1)) && (row_q >= RW'(WIN - 1));

  // ==========================================================================
  // raster counters
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (shift_en_i) begin
      if (col_last) begin
        col_q <= '0;
        row_q <= row_last ? '0 : row_q + 1'b1;  // wraps into the next frame.
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_full_q   <= 1'b0;
      win_valid_q  <= 1'b0;
      frame_last_q <= 1'b0;
    end else begin
      win_valid_q <= shift_en_i && in_image;
      if (shift_en_i) begin
        win_full_q   <= in_image;  // held until the next pixel.
        frame_last_q <= col_last && row_last;
      end
    end
  end

  // ==========================================================================
  // window shift
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_q <= '0;
    end else if (shift_en_i) begin
      for (int r = 0; r < WIN; r++) begin
        for (int c = 0; c < WIN - 1; c++) begin
          win_q[r*WIN + c] <= win_q[r*WIN + c + 1];
        end
        win_q[r*WIN + WIN - 1] <= taps_i[WIN - 1 - r];  // top row is oldest line.
      end
    end
  end

  assign win_full_o      = win_full_q;
  assign wbus.win        = win_q;
  assign wbus.win_valid  = win_valid_q;
  assign wbus.frame_last = frame_last_q;

endmodule

`default_nettype wire

// File: verilog/window_reduce.sv
`default_nettype none

module window_reduce import conv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  op_t     op_i,
  window_if.red   wbus,
  output logic    res_valid_o,
  output result_t res_data_o
);

  logic    first_q;  // next window opens a frame.
  op_t     op_q;
  op_t     op_cur;
  result_t sum_d;
  pixel_t  max_d;
  pixel_t  min_d;
  result_t res_d;

  // opcode sampled at frame start, then held.
  assign op_cur = first_q ? op_i : op_q;

  always_comb begin
    sum_d = '0;
    max_d = '0;
    min_d = '1;
    for (int i = 0; i < WIN*WIN; i++) begin
      sum_d = sum_d + result_t'(wbus.win[i]);
      if (wbus.win[i] > max_d) max_d = wbus.win[i];
      if (wbus.win[i] < min_d) min_d = wbus.win[i];
    end
  end

  always_comb begin
    case (op_cur)
      OP_MAX:  res_d = result_t'(max_d);  // zero extended.
      OP_MIN:  res_d = result_t'(min_d);
      default: res_d = sum_d;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      first_q     <= 1'b1;
      op_q        <= OP_SUM;
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= wbus.win_valid;
      if (wbus.win_valid) begin
        first_q <= wbus.frame_last;
        if (first_q) op_q <= op_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wbus.win_valid) res_data_o <= res_d;  // held for the output link.
  end

endmodule

`default_nettype wire

// File: verilog/window_ctrl.sv
`default_nettype none

module window_ctrl import conv_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic pix_req_i,
  output logic pix_ack_o,
  output logic shift_en_o,
  input  logic win_full_i,
  input  logic res_valid_i,
  output logic res_req_o,
  input  logic res_ack_i
);

  ctrl_state_t state_q;
  logic        pix_ack_q;
  logic        shift_en_q;
  logic        res_req_q;
  logic        res_seen_q;  // result arrived while still in ST_ACK.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      pix_ack_q  <= 1'b0;
      shift_en_q <= 1'b0;
      res_req_q  <= 1'b0;
      res_seen_q <= 1'b0;
    end else begin
      shift_en_q <= 1'b0;
      if (res_valid_i) res_seen_q <= 1'b1;
      case (state_q)
        ST_IDLE: if (pix_req_i) begin
          pix_ack_q  <= 1'b1;
          shift_en_q <= 1'b1;  // take the pixel with the ack edge.
          state_q    <= ST_ACK;
        end
        ST_ACK: if (!pix_req_i) begin
          pix_ack_q <= 1'b0;
          state_q   <= win_full_i ? ST_WAIT_WIN : ST_IDLE;
        end
        ST_WAIT_WIN: if (res_valid_i || res_seen_q) begin
          res_seen_q <= 1'b0;
          res_req_q  <= 1'b1;
          state_q    <= ST_RES_REQ;
        end
        ST_RES_REQ: if (res_ack_i) begin
          res_req_q <= 1'b0;
          state_q   <= ST_RES_DROP;
        end
        ST_RES_DROP: if (!res_ack_i) state_q <= ST_IDLE;  // sink done.
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign pix_ack_o  = pix_ack_q;
  assign shift_en_o = shift_en_q;
  assign res_req_o  = res_req_q;

endmodule

`default_nettype wire

// File: verilog/window_filter_top.sv
`default_nettype none

module window_filter_top import conv_pkg::*; #(
  parameter int COLS = 16,
  parameter int ROWS = 12
) (
  input  logic    clk,
  input  logic    rst_n,
  input  op_t     op_i,
  input  logic    pix_req_i,
  input  pixel_t  pix_data_i,
  output logic    pix_ack_o,
  output logic    res_req_o,
  output result_t res_data_o,
  input  logic    res_ack_i
);

  logic             shift_en;
  logic             win_full;
  logic             res_valid;
  pixel_t [WIN-1:0] taps;

  window_if wbus ();

  line_buffer #(
    .COLS (COLS)
  ) line_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en_i (shift_en),
    .pix_i      (pix_data_i),
    .taps_o     (taps)
  );

  window_7x7_datapath #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) window_7x7_datapath_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en_i (shift_en),
    .taps_i     (taps),
    .win_full_o (win_full),
    .wbus       (wbus.dp)
  );

  window_reduce window_reduce_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_i        (op_i),
    .wbus        (wbus.red),
    .res_valid_o (res_valid),
    .res_data_o  (res_data_o)
  );

  window_ctrl window_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_req_i   (pix_req_i),
    .pix_ack_o   (pix_ack_o),
    .shift_en_o  (shift_en),
    .win_full_i  (win_full),
    .res_valid_i (res_valid),
    .res_req_o   (res_req_o),
    .res_ack_i   (res_ack_i)
  );

endmodule

`default_nettype wire

// File: test/window_filter_tb.sv
`default_nettype none

module window_filter_tb import conv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int COLS  = 16;
  localparam int ROWS  = 12;
  localparam int NRES  = (COLS - WIN + 1) * (ROWS - WIN + 1);
  localparam int LIMIT = 5000;  // cycles per wait.

  logic        clk;
  logic        rst_n;
  op_t         op_i;
  logic        pix_req_i;
  pixel_t      pix_data_i;
  logic        pix_ack_o;
  logic        res_req_o;
  result_t     res_data_o;
  logic        res_ack_i;
  logic [31:0] img_seed;
  logic [31:0] sink_seed;
  logic [31:0] src_seed;
  pixel_t      img [ROWS][COLS];
  result_t     exp_q [$];  // model results in raster order.
  string       test_name;
  int          n_got;
  int          value_errs;
  int          proto_errs;
  int          timeouts;
  logic        prev_req;
  logic        prev_ack;
  logic        prev_rreq;
  logic        prev_rack;

  window_filter_top #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) window_filter_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_i       (op_i),
    .pix_req_i  (pix_req_i),
    .pix_data_i (pix_data_i),
    .pix_ack_o  (pix_ack_o),
    .res_req_o  (res_req_o),
    .res_data_o (res_data_o),
    .res_ack_i  (res_ack_i)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // ==========================================================================
  // checks and end of run
  // ==========================================================================

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %0d actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("** Error: %s result count expected %0d actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error: %s expected %b actual %b", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic finish_run();
    $display("value errors %0d, protocol errors %0d, timeouts %0d",
             value_errs, proto_errs, timeouts);
    if (value_errs + proto_errs + timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("timed out waiting for %s during %s", what, test_name);
    timeouts++;
    finish_run();
  endtask

  // ==========================================================================
  // handshake waits
  // ==========================================================================

  task automatic wait_pix_ack(input logic level);
    int n;
    n = 0;
    @(posedge clk);
    while (pix_ack_o !== level) begin
      if (n == LIMIT) timed_out("pix_ack_o");
      n++;
      @(posedge clk);
    end
  endtask

  task automatic wait_res_req(input logic level);
    int n;
    n = 0;
    @(posedge clk);
    while (res_req_o !== level) begin
      if (n == LIMIT) timed_out("res_req_o");
      n++;
      @(posedge clk);
    end
  endtask

  task automatic wait_results(input int target);
    int n;
    n = 0;
    while (n_got < target) begin
      if (n == LIMIT) timed_out("the frame's results");
      n++;
      @(posedge clk);
    end
  endtask

  task automatic send_pixel(input pixel_t p);
    int hold;
    pix_data_i <= p;
    pix_req_i  <= 1'b1;
    wait_pix_ack(1'b1);
    src_seed = xorshift(src_seed);
    hold = int'(src_seed % 4);
    repeat (hold) @(posedge clk);  // slow source.
    pix_req_i <= 1'b0;
    wait_pix_ack(1'b0);
  endtask

  // random image, model results, then the pixels in raster order.
  task automatic run_frame(input string name, input op_t op);
    int start;
    int s;
    int mx;
    int mn;
    int v;
    test_name = name;
    op_i <= op;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img_seed = xorshift(img_seed);
        img[r][c] = img_seed[7:0];
      end
    end
    for (int r = WIN - 1; r < ROWS; r++) begin
      for (int c = WIN - 1; c < COLS; c++) begin
        s  = 0;
        mx = 0;
        mn = 255;
        for (int dr = 0; dr < WIN; dr++) begin
          for (int dc = 0; dc < WIN; dc++) begin
            v = int'(img[r-dr][c-dc]);
            s = s + v;
            if (v > mx) mx = v;
            if (v < mn) mn = v;
          end
        end
        case (op)
          OP_MAX:  exp_q.push_back(result_t'(mx));
          OP_MIN:  exp_q.push_back(result_t'(mn));
          default: exp_q.push_back(result_t'(s));
        endcase
      end
    end
    start = n_got;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        send_pixel(img[r][c]);
        if (r == WIN - 1 && c == WIN - 1) begin
          op_i <= (op == OP_SUM) ? OP_MAX : OP_SUM;  // frame opcode already latched.
        end
      end
    end
    wait_results(start + NRES);
    repeat (10) @(posedge clk);  // late extras would show here.
    check_count(name, NRES, n_got - start);
  endtask

  // ==========================================================================
  // processes
  // ==========================================================================

  // four-phase order on both links.
  always @(posedge clk) begin
    if (rst_n) begin
      if (pix_ack_o && !prev_ack && !prev_req) begin
        $display("pix_ack_o rose with no pixel request in %s", test_name);
        proto_errs++;
      end
      if (!pix_ack_o && prev_ack && prev_req) begin
        $display("pix_ack_o fell while pix_req_i was still high in %s", test_name);
        proto_errs++;
      end
      if (pix_ack_o && !prev_ack && (res_req_o || res_ack_i || prev_rreq || prev_rack)) begin
        $display("pix_ack_o rose during a result handshake in %s", test_name);
        proto_errs++;
      end
      if (res_req_o && !prev_rreq && prev_rack) begin
        $display("res_req_o rose before res_ack_i had fallen in %s", test_name);
        proto_errs++;
      end
      if (!res_req_o && prev_rreq && !prev_rack) begin
        $display("res_req_o fell with no res_ack_i in %s", test_name);
        proto_errs++;
      end
    end
    prev_req  <= pix_req_i;
    prev_ack  <= pix_ack_o;
    prev_rreq <= res_req_o;
    prev_rack <= res_ack_i;
  end

  initial begin : sink
    int d;
    forever begin
      wait_res_req(1'b1);
      if (exp_q.size() == 0) begin
        $display("result %0d arrived with none expected in %s", res_data_o, test_name);
        proto_errs++;
      end else begin
        check_result(test_name, exp_q.pop_front(), res_data_o);
      end
      n_got++;
      sink_seed = xorshift(sink_seed);
      d = int'(sink_seed % 6);
      repeat (d) @(posedge clk);  // back-pressure.
      res_ack_i <= 1'b1;
      wait_res_req(1'b0);
      res_ack_i <= 1'b0;
    end
  end

  initial begin : source
    clk        = 1'b0;
    rst_n      <= 1'b0;
    op_i       <= OP_SUM;
    pix_req_i  <= 1'b0;
    pix_data_i <= '0;
    res_ack_i  <= 1'b0;
    img_seed   = 32'h52dd;
    sink_seed  = 32'h52dd;
    src_seed   = 32'h52dd;
    n_got      = 0;
    value_errs = 0;
    proto_errs = 0;
    timeouts   = 0;
    test_name  = "reset";
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_name = "reset_idle";
    repeat (20) begin
      @(posedge clk);
      check_level("reset_idle pix_ack_o", 1'b0, pix_ack_o);
      check_level("reset_idle res_req_o", 1'b0, res_req_o);
    end
    run_frame("frame0_sum", OP_SUM);
    run_frame("frame1_max", OP_MAX);
    run_frame("frame2_min", OP_MIN);
    run_frame("frame3_sum", OP_SUM);  // counters wrapped three times.
    run_frame("frame4_min", OP_MIN);
    repeat (20) @(posedge clk);
    check_count("all_frames", 5 * NRES, n_got);
    finish_run();
  end

endmodule

`default_nettype wire

// File: list.f
verilog/conv_pkg.sv
verilog/window_if.sv
verilog/line_buffer.sv
verilog/window_7x7_datapath.sv
verilog/window_reduce.sv
verilog/window_ctrl.sv
verilog/window_filter_top.sv
test/window_filter_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module window_filter_tb -f list.f
	./obj_dir/Vwindow_filter_tb | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
